/* hdl/nebula_pkg.sv */
// ##########################################################
// Shuttle harness shared types
// ##########################################################
package nebula_pkg;

    // Wishbone widths
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;
    typedef logic [13:0] word_ofs_t;    // adr[15:2] inside a slave

    // Pads and logic analyzer
    localparam int NUM_PADS  = 38;
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = 32;
    localparam int LA_W      = NUM_LANES * LANE_W;

    typedef logic [NUM_PADS-1:0] gpio_vec_t;
    typedef logic [LA_W-1:0]     la_vec_t;

    typedef logic [3:0] team_idx_t;     // 0 is no team, 1..15 a team

    // Address regions from adr[19:16]
    typedef logic [3:0] region_t;
    localparam region_t REGION_SRAM      = 4'd0;
    localparam region_t REGION_GPIO      = 4'd1;
    localparam region_t REGION_LA        = 4'd2;
    localparam region_t REGION_TEAM_BASE = 4'd3;    // Team n sits at region 2+n

    // Merge a write into the old word by byte lane
    function automatic wb_data_t byte_merge(wb_data_t old_w, wb_data_t new_w, wb_sel_t sel);
        wb_data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

endpackage

/* hdl/wb_decoder.sv */
`timescale 1ns/100ps
// ##########################################################
// Wishbone region decoder
// ##########################################################
module wb_decoder #(
    parameter int NUM_TEAMS = 2
) (
    input  logic                                 wb_clk_i,
    input  logic                                 rst_n_i,
    input  nebula_pkg::wb_addr_t                 wbs_adr_i,
    input  logic                                 wbs_cyc_i,
    input  logic                                 wbs_stb_i,
    input  logic                                 ack_sram_i,
    input  logic                                 ack_gpio_i,
    input  logic                                 ack_la_i,
    input  logic [NUM_TEAMS-1:0]                 ack_team_i,
    input  nebula_pkg::wb_data_t                 dat_sram_i,
    input  nebula_pkg::wb_data_t                 dat_gpio_i,
    input  nebula_pkg::wb_data_t                 dat_la_i,
    input  nebula_pkg::wb_data_t [NUM_TEAMS-1:0] dat_team_i,
    output logic                                 cyc_sram_o,
    output logic                                 cyc_gpio_o,
    output logic                                 cyc_la_o,
    output logic [NUM_TEAMS-1:0]                 cyc_team_o,
    output logic                                 wbs_ack_o,
    output nebula_pkg::wb_data_t                 wbs_dat_o
);

    nebula_pkg::region_t region;
    logic [NUM_TEAMS-1:0] team_hit;     // One-hot team match
    logic                 unmapped;
    logic                 unm_req;
    logic                 unm_ack_q;    // Own ack for dead regions
    logic                 unm_served_q; // Acked, stb still high

    assign region   = wbs_adr_i[19:16];
    assign unmapped = int'(region) >= int'(nebula_pkg::REGION_TEAM_BASE) + NUM_TEAMS;
    assign unm_req  = wbs_cyc_i & wbs_stb_i & unmapped;

    always_comb begin
        for (int t = 0; t < NUM_TEAMS; t++) begin
            team_hit[t] = int'(region) == int'(nebula_pkg::REGION_TEAM_BASE) + t;
        end
    end

    // Only cyc gets steered
    assign cyc_sram_o = wbs_cyc_i & (region == nebula_pkg::REGION_SRAM);
    assign cyc_gpio_o = wbs_cyc_i & (region == nebula_pkg::REGION_GPIO);
    assign cyc_la_o   = wbs_cyc_i & (region == nebula_pkg::REGION_LA);
    assign cyc_team_o = {NUM_TEAMS{wbs_cyc_i}} & team_hit;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            unm_ack_q    <= 1'b0;
            unm_served_q <= 1'b0;
        end else begin
            unm_ack_q    <= unm_req & ~unm_ack_q & ~unm_served_q;   // Single-cycle pulse
            unm_served_q <= unm_req & (unm_ack_q | unm_served_q);   // Clears when stb drops
        end
    end

    // Return path, combinational by region
    always_comb begin
        wbs_ack_o = unm_ack_q;
        wbs_dat_o = '0;                 // Dead regions read zero
        if (region == nebula_pkg::REGION_SRAM) begin
            wbs_ack_o = ack_sram_i;
            wbs_dat_o = dat_sram_i;
        end else if (region == nebula_pkg::REGION_GPIO) begin
            wbs_ack_o = ack_gpio_i;
            wbs_dat_o = dat_gpio_i;
        end else if (region == nebula_pkg::REGION_LA) begin
            wbs_ack_o = ack_la_i;
            wbs_dat_o = dat_la_i;
        end
        for (int t = 0; t < NUM_TEAMS; t++) begin
            if (team_hit[t]) begin
                wbs_ack_o = ack_team_i[t];
                wbs_dat_o = dat_team_i[t];
            end
        end
    end

endmodule

/* hdl/gpio_control.sv */
`timescale 1ns/100ps
// ##########################################################
// GPIO pad owner select
// ##########################################################
module gpio_control #(
    parameter int NUM_TEAMS = 2
) (
    input  logic                                             wb_clk_i,
    input  logic                                             rst_n_i,
    input  logic                                             wbs_cyc_i,
    input  logic                                             wbs_stb_i,
    input  logic                                             wbs_we_i,
    input  nebula_pkg::wb_sel_t                              wbs_sel_i,
    input  nebula_pkg::wb_addr_t                             wbs_adr_i,
    input  nebula_pkg::wb_data_t                             wbs_dat_i,
    input  logic [nebula_pkg::NUM_PADS*(NUM_TEAMS+1)-1:0]    gpio_out_flat_i,
    input  logic [nebula_pkg::NUM_PADS*(NUM_TEAMS+1)-1:0]    gpio_oeb_flat_i,
    output logic                                             wbs_ack_o,
    output nebula_pkg::wb_data_t                             wbs_dat_o,
    output nebula_pkg::gpio_vec_t                            gpio_out_o,
    output nebula_pkg::gpio_vec_t                            gpio_oeb_o
);

    localparam int NP = nebula_pkg::NUM_PADS;

    nebula_pkg::team_idx_t pad_sel_q [NP];  // Owner per pad
    nebula_pkg::word_ofs_t ofs;
    nebula_pkg::wb_data_t  rd_word;
    nebula_pkg::wb_data_t  wr_word;
    logic                  req;
    logic                  hit;             // First edge of an access
    logic                  served_q;

    assign ofs     = wbs_adr_i[15:2];
    assign req     = wbs_cyc_i & wbs_stb_i;
    assign hit     = req & ~wbs_ack_o & ~served_q;
    assign wr_word = nebula_pkg::byte_merge(rd_word, wbs_dat_i, wbs_sel_i);

    // Pad 8*ofs+k lives in nibble k, offsets 0..4
    always_comb begin
        rd_word = '0;
        for (int p = 0; p < NP; p++) begin
            if (int'(ofs) == p / 8)
                rd_word[4*(p%8) +: 4] = pad_sel_q[p];
        end
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wbs_ack_o <= 1'b0;
            served_q  <= 1'b0;
            for (int p = 0; p < NP; p++) begin
                pad_sel_q[p] <= '0;         // Nobody owns a pad
            end
        end else begin
            wbs_ack_o <= hit;
            served_q  <= req & (wbs_ack_o | served_q);
            for (int p = 0; p < NP; p++) begin
                if (hit && wbs_we_i && int'(ofs) == p / 8)
                    pad_sel_q[p] <= wr_word[4*(p%8) +: 4];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (hit)
            wbs_dat_o <= rd_word;           // Pre-write value
    end

    // Pad mux, bad selects fall back to entry 0
    always_comb begin
        for (int p = 0; p < NP; p++) begin
            if (int'(pad_sel_q[p]) <= NUM_TEAMS) begin
                gpio_out_o[p] = gpio_out_flat_i[NP*pad_sel_q[p] + p];
                gpio_oeb_o[p] = gpio_oeb_flat_i[NP*pad_sel_q[p] + p];
            end else begin
                gpio_out_o[p] = gpio_out_flat_i[p];
                gpio_oeb_o[p] = gpio_oeb_flat_i[p];
            end
        end
    end

endmodule

/* hdl/la_control.sv */
`timescale 1ns/100ps
// ##########################################################
// Logic analyzer lane select
// ##########################################################
module la_control #(
    parameter int NUM_TEAMS = 2
) (
    input  logic                                         wb_clk_i,
    input  logic                                         rst_n_i,
    input  logic                                         wbs_cyc_i,
    input  logic                                         wbs_stb_i,
    input  logic                                         wbs_we_i,
    input  nebula_pkg::wb_sel_t                          wbs_sel_i,
    input  nebula_pkg::wb_addr_t                         wbs_adr_i,
    input  nebula_pkg::wb_data_t                         wbs_dat_i,
    input  logic [nebula_pkg::LA_W*(NUM_TEAMS+1)-1:0]    la_flat_i,
    output logic                                         wbs_ack_o,
    output nebula_pkg::wb_data_t                         wbs_dat_o,
    output nebula_pkg::la_vec_t                          la_data_out_o
);

    localparam int NL = nebula_pkg::NUM_LANES;
    localparam int LW = nebula_pkg::LANE_W;

    nebula_pkg::team_idx_t lane_sel_q [NL];
    nebula_pkg::word_ofs_t ofs;
    nebula_pkg::wb_data_t  rd_word;
    nebula_pkg::wb_data_t  wr_word;
    logic                  req;
    logic                  hit;
    logic                  served_q;

    assign ofs     = wbs_adr_i[15:2];
    assign req     = wbs_cyc_i & wbs_stb_i;
    assign hit     = req & ~wbs_ack_o & ~served_q;
    assign wr_word = nebula_pkg::byte_merge(rd_word, wbs_dat_i, wbs_sel_i);

    always_comb begin
        rd_word = '0;                       // Only offset 0 is backed
        for (int l = 0; l < NL; l++) begin
            if (ofs == '0)
                rd_word[4*l +: 4] = lane_sel_q[l];
        end
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wbs_ack_o <= 1'b0;
            served_q  <= 1'b0;
            for (int l = 0; l < NL; l++) begin
                lane_sel_q[l] <= '0;
            end
        end else begin
            wbs_ack_o <= hit;
            served_q  <= req & (wbs_ack_o | served_q);
            for (int l = 0; l < NL; l++) begin
                if (hit && wbs_we_i && ofs == '0)
                    lane_sel_q[l] <= wr_word[4*l +: 4];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (hit)
            wbs_dat_o <= rd_word;
    end

    // Lane l copies lane l of its team
    always_comb begin
        for (int l = 0; l < NL; l++) begin
            if (int'(lane_sel_q[l]) <= NUM_TEAMS)
                la_data_out_o[LW*l +: LW] = la_flat_i[nebula_pkg::LA_W*lane_sel_q[l] + LW*l +: LW];
            else
                la_data_out_o[LW*l +: LW] = '0;
        end
    end

endmodule

/* hdl/wb_sram.sv */
`timescale 1ns/100ps
// ##########################################################
// Wishbone word SRAM
// ##########################################################
module wb_sram #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_we_i,
    input  nebula_pkg::wb_sel_t  wbs_sel_i,
    input  nebula_pkg::wb_addr_t wbs_adr_i,
    input  nebula_pkg::wb_data_t wbs_dat_i,
    output logic                 wbs_ack_o,
    output nebula_pkg::wb_data_t wbs_dat_o
);

    localparam int AW = $clog2(SRAM_DEPTH);

    nebula_pkg::wb_data_t mem [SRAM_DEPTH];
    logic [AW-1:0]        idx;              // Low word-offset bits, upper ones alias
    logic                 req;
    logic                 hit;
    logic                 served_q;

    assign idx = wbs_adr_i[2 +: AW];
    assign req = wbs_cyc_i & wbs_stb_i;
    assign hit = req & ~wbs_ack_o & ~served_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wbs_ack_o <= 1'b0;
            served_q  <= 1'b0;
        end else begin
            wbs_ack_o <= hit;
            served_q  <= req & (wbs_ack_o | served_q);
        end
    end

    // Array and read port
    always_ff @(posedge wb_clk_i) begin
        if (hit) begin
            if (wbs_we_i)
                mem[idx] <= nebula_pkg::byte_merge(mem[idx], wbs_dat_i, wbs_sel_i);
            wbs_dat_o <= mem[idx];          // Shown with ack
        end
    end

endmodule

/* hdl/team_sample.sv */
`timescale 1ns/100ps
// ##########################################################
// Sample team counter project
// ##########################################################
module team_sample #(
    parameter int TEAM_ID = 1
) (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,
    input  logic                  wbs_cyc_i,
    input  logic                  wbs_stb_i,
    input  logic                  wbs_we_i,
    input  nebula_pkg::wb_sel_t   wbs_sel_i,
    input  nebula_pkg::wb_addr_t  wbs_adr_i,
    input  nebula_pkg::wb_data_t  wbs_dat_i,
    input  nebula_pkg::gpio_vec_t gpio_in_i,
    output logic                  wbs_ack_o,
    output nebula_pkg::wb_data_t  wbs_dat_o,
    output nebula_pkg::gpio_vec_t gpio_out_o,
    output nebula_pkg::gpio_vec_t gpio_oeb_o,
    output nebula_pkg::la_vec_t   la_data_out_o
);

    logic [1:0]            ctrl_q;          // Bit 0 count, bit 1 drive pads
    nebula_pkg::wb_data_t  count_q;
    nebula_pkg::word_ofs_t ofs;
    nebula_pkg::wb_data_t  rd_word;
    nebula_pkg::wb_data_t  wr_word;
    logic                  req;
    logic                  hit;
    logic                  served_q;

    assign ofs     = wbs_adr_i[15:2];
    assign req     = wbs_cyc_i & wbs_stb_i;
    assign hit     = req & ~wbs_ack_o & ~served_q;
    assign wr_word = nebula_pkg::byte_merge(rd_word, wbs_dat_i, wbs_sel_i);

    always_comb begin
        case (ofs)
            14'd0:   rd_word = nebula_pkg::wb_data_t'(ctrl_q);
            14'd1:   rd_word = count_q;
            14'd2:   rd_word = gpio_in_i[31:0];     // Low pads only
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wbs_ack_o <= 1'b0;
            served_q  <= 1'b0;
            ctrl_q    <= '0;
            count_q   <= '0;
        end else begin
            wbs_ack_o <= hit;
            served_q  <= req & (wbs_ack_o | served_q);
            if (hit && wbs_we_i && ofs == '0)
                ctrl_q <= wr_word[1:0];
            if (ctrl_q[0])
                count_q <= count_q + 32'd1;     // Free-running while enabled
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (hit)
            wbs_dat_o <= rd_word;
    end

    assign gpio_out_o = nebula_pkg::gpio_vec_t'(count_q);
    assign gpio_oeb_o = {nebula_pkg::NUM_PADS{~ctrl_q[1]}};    // Low drives

    // Lanes 3..0: ctrl, id, ~count, count
    assign la_data_out_o = {nebula_pkg::wb_data_t'(ctrl_q),
                            nebula_pkg::wb_data_t'(TEAM_ID),
                            ~count_q,
                            count_q};

endmodule

/* hdl/nebula_ii.sv */
`timescale 1ns/100ps
// ##########################################################
// Shuttle user-area harness
// ##########################################################
module nebula_ii #(
    parameter int NUM_TEAMS  = 2,
    parameter int SRAM_DEPTH = 256
) (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,
    input  logic                  wbs_stb_i,
    input  logic                  wbs_cyc_i,
    input  logic                  wbs_we_i,
    input  nebula_pkg::wb_sel_t   wbs_sel_i,
    input  nebula_pkg::wb_data_t  wbs_dat_i,
    input  nebula_pkg::wb_addr_t  wbs_adr_i,
    input  nebula_pkg::gpio_vec_t io_in_i,
    output logic                  wbs_ack_o,
    output nebula_pkg::wb_data_t  wbs_dat_o,
    output nebula_pkg::la_vec_t   la_data_out_o,
    output nebula_pkg::gpio_vec_t io_out_o,
    output nebula_pkg::gpio_vec_t io_oeb_o
);

    localparam int NP = nebula_pkg::NUM_PADS;
    localparam int LW = nebula_pkg::LA_W;

    logic                                 cyc_sram;
    logic                                 cyc_gpio;
    logic                                 cyc_la;
    logic [NUM_TEAMS-1:0]                 cyc_team;     // Team n on bit n-1
    logic                                 ack_sram;
    logic                                 ack_gpio;
    logic                                 ack_la;
    logic [NUM_TEAMS-1:0]                 ack_team;
    nebula_pkg::wb_data_t                 dat_sram;
    nebula_pkg::wb_data_t                 dat_gpio;
    nebula_pkg::wb_data_t                 dat_la;
    nebula_pkg::wb_data_t [NUM_TEAMS-1:0] dat_team;

    // Flat per-team outputs, entry 0 is the idle default
    logic [NP*(NUM_TEAMS+1)-1:0] gpio_out_flat;
    logic [NP*(NUM_TEAMS+1)-1:0] gpio_oeb_flat;
    logic [LW*(NUM_TEAMS+1)-1:0] la_flat;

    assign gpio_out_flat[NP-1:0] = '0;
    assign gpio_oeb_flat[NP-1:0] = '1;     // Pad not driven
    assign la_flat[LW-1:0]       = '0;

    wb_decoder #(
        .NUM_TEAMS(NUM_TEAMS)
    ) u_decoder (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .ack_sram_i(ack_sram),
        .ack_gpio_i(ack_gpio),
        .ack_la_i  (ack_la),
        .ack_team_i(ack_team),
        .dat_sram_i(dat_sram),
        .dat_gpio_i(dat_gpio),
        .dat_la_i  (dat_la),
        .dat_team_i(dat_team),
        .cyc_sram_o(cyc_sram),
        .cyc_gpio_o(cyc_gpio),
        .cyc_la_o  (cyc_la),
        .cyc_team_o(cyc_team),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o)
    );

    gpio_control #(
        .NUM_TEAMS(NUM_TEAMS)
    ) u_gpio (
        .wb_clk_i       (wb_clk_i),
        .rst_n_i        (rst_n_i),
        .wbs_cyc_i      (cyc_gpio),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_sel_i      (wbs_sel_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_dat_i      (wbs_dat_i),
        .gpio_out_flat_i(gpio_out_flat),
        .gpio_oeb_flat_i(gpio_oeb_flat),
        .wbs_ack_o      (ack_gpio),
        .wbs_dat_o      (dat_gpio),
        .gpio_out_o     (io_out_o),
        .gpio_oeb_o     (io_oeb_o)
    );

    la_control #(
        .NUM_TEAMS(NUM_TEAMS)
    ) u_la (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .wbs_cyc_i    (cyc_la),
        .wbs_stb_i    (wbs_stb_i),
        .wbs_we_i     (wbs_we_i),
        .wbs_sel_i    (wbs_sel_i),
        .wbs_adr_i    (wbs_adr_i),
        .wbs_dat_i    (wbs_dat_i),
        .la_flat_i    (la_flat),
        .wbs_ack_o    (ack_la),
        .wbs_dat_o    (dat_la),
        .la_data_out_o(la_data_out_o)
    );

    wb_sram #(
        .SRAM_DEPTH(SRAM_DEPTH)
    ) u_sram (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .wbs_cyc_i(cyc_sram),
        .wbs_stb_i(wbs_stb_i),
        .wbs_we_i (wbs_we_i),
        .wbs_sel_i(wbs_sel_i),
        .wbs_adr_i(wbs_adr_i),
        .wbs_dat_i(wbs_dat_i),
        .wbs_ack_o(ack_sram),
        .wbs_dat_o(dat_sram)
    );

    // One counter project per team, slice t of each flat bus
    for (genvar t = 1; t <= NUM_TEAMS; t++) begin : g_team
        team_sample #(
            .TEAM_ID(t)
        ) u_team (
            .wb_clk_i     (wb_clk_i),
            .rst_n_i      (rst_n_i),
            .wbs_cyc_i    (cyc_team[t-1]),
            .wbs_stb_i    (wbs_stb_i),
            .wbs_we_i     (wbs_we_i),
            .wbs_sel_i    (wbs_sel_i),
            .wbs_adr_i    (wbs_adr_i),
            .wbs_dat_i    (wbs_dat_i),
            .gpio_in_i    (io_in_i),
            .wbs_ack_o    (ack_team[t-1]),
            .wbs_dat_o    (dat_team[t-1]),
            .gpio_out_o   (gpio_out_flat[NP*t +: NP]),
            .gpio_oeb_o   (gpio_oeb_flat[NP*t +: NP]),
            .la_data_out_o(la_flat[LW*t +: LW])
        );
    end

endmodule

/* tests/tb_nebula_ii.sv */
`timescale 1ns/100ps
// ##########################################################
// Shuttle harness directed testbench
// ##########################################################
module tb_nebula_ii;

    localparam int NUM_TEAMS  = 2;
    localparam int SRAM_DEPTH = 256;
    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 6;
    localparam int ACK_LIMIT  = 4;      // Cycles to wait for ack

    logic                  wb_clk_i;
    logic                  rst_n_i;
    logic                  wbs_stb_i;
    logic                  wbs_cyc_i;
    logic                  wbs_we_i;
    nebula_pkg::wb_sel_t   wbs_sel_i;
    nebula_pkg::wb_data_t  wbs_dat_i;
    nebula_pkg::wb_addr_t  wbs_adr_i;
    nebula_pkg::gpio_vec_t io_in_i;
    logic                  wbs_ack_o;
    nebula_pkg::wb_data_t  wbs_dat_o;
    nebula_pkg::la_vec_t   la_data_out_o;
    nebula_pkg::gpio_vec_t io_out_o;
    nebula_pkg::gpio_vec_t io_oeb_o;

    integer               seed = 32'h728e;
    nebula_pkg::wb_data_t c1;           // Team 1 counter once frozen

    nebula_ii #(
        .NUM_TEAMS (NUM_TEAMS),
        .SRAM_DEPTH(SRAM_DEPTH)
    ) u_dut (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .wbs_stb_i    (wbs_stb_i),
        .wbs_cyc_i    (wbs_cyc_i),
        .wbs_we_i     (wbs_we_i),
        .wbs_sel_i    (wbs_sel_i),
        .wbs_dat_i    (wbs_dat_i),
        .wbs_adr_i    (wbs_adr_i),
        .io_in_i      (io_in_i),
        .wbs_ack_o    (wbs_ack_o),
        .wbs_dat_o    (wbs_dat_o),
        .la_data_out_o(la_data_out_o),
        .io_out_o     (io_out_o),
        .io_oeb_o     (io_oeb_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
    end

    // Region in adr[19:16] and word offset in adr[15:2]
    function automatic nebula_pkg::wb_addr_t reg_addr(nebula_pkg::region_t region, int ofs);
        return {12'h000, region, ofs[13:0], 2'b00};
    endfunction

    function automatic nebula_pkg::region_t team_region(int t);
        return nebula_pkg::region_t'(int'(nebula_pkg::REGION_TEAM_BASE) + t - 1);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input nebula_pkg::wb_data_t exp,
                              input nebula_pkg::wb_data_t act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
                                $time, name, exp, act));
    endtask

    task automatic check_gpio(input string name, input nebula_pkg::gpio_vec_t exp,
                              input nebula_pkg::gpio_vec_t act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
                                $time, name, exp, act));
    endtask

    task automatic check_la(input string name, input nebula_pkg::la_vec_t exp,
                            input nebula_pkg::la_vec_t act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
                                $time, name, exp, act));
    endtask

    // Ack sampled mid-cycle and request dropped on the next edge
    task automatic wait_ack(output nebula_pkg::wb_data_t dat);
        int n;
        n = 0;
        @(negedge wb_clk_i);
        while (!wbs_ack_o) begin
            n++;
            if (n >= ACK_LIMIT)
                abort_run($sformatf("no ack within %0d cycles for address %h",
                                    ACK_LIMIT, wbs_adr_i));
            @(negedge wb_clk_i);
        end
        dat = wbs_dat_o;
        @(posedge wb_clk_i);
        wbs_cyc_i <= 1'b0;
        wbs_stb_i <= 1'b0;
        wbs_we_i  <= 1'b0;
    endtask

    task automatic wb_write(input nebula_pkg::wb_addr_t adr, input nebula_pkg::wb_data_t dat,
                            input nebula_pkg::wb_sel_t sel);
        nebula_pkg::wb_data_t unused;
        @(posedge wb_clk_i);
        wbs_adr_i <= adr;
        wbs_dat_i <= dat;
        wbs_sel_i <= sel;
        wbs_we_i  <= 1'b1;
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wait_ack(unused);
    endtask

    task automatic wb_read(input nebula_pkg::wb_addr_t adr, output nebula_pkg::wb_data_t dat);
        @(posedge wb_clk_i);
        wbs_adr_i <= adr;
        wbs_sel_i <= 4'hf;
        wbs_we_i  <= 1'b0;
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wait_ack(dat);
    endtask

    task automatic reset_state();
        nebula_pkg::wb_data_t rd;
        @(negedge wb_clk_i);
        check_gpio("io_oeb_o", '1, io_oeb_o);          // No pad owned
        check_gpio("io_out_o", '0, io_out_o);
        check_la("la_data_out_o", '0, la_data_out_o);
        for (int w = 0; w < 5; w++) begin
            wb_read(reg_addr(nebula_pkg::REGION_GPIO, w), rd);
            check_data($sformatf("gpio_sel[%0d]", w), 32'h0, rd);
        end
        wb_read(reg_addr(nebula_pkg::REGION_LA, 0), rd);
        check_data("la_sel", 32'h0, rd);
    endtask

    task automatic sram_byte_lanes();
        nebula_pkg::wb_data_t ref_mem [16];
        nebula_pkg::wb_data_t d;
        nebula_pkg::wb_data_t rd;
        nebula_pkg::wb_sel_t  sel;
        for (int i = 0; i < 16; i++) begin    // Full words first so no byte stays X
            d = $random(seed);
            ref_mem[i] = d;
            wb_write(reg_addr(nebula_pkg::REGION_SRAM, i * 17), d, 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            d   = $random(seed);
            sel = $random(seed);
            for (int b = 0; b < 4; b++) begin
                if (sel[b])
                    ref_mem[i][8*b +: 8] = d[8*b +: 8];
            end
            wb_write(reg_addr(nebula_pkg::REGION_SRAM, i * 17), d, sel);
        end
        for (int i = 0; i < 16; i++) begin
            wb_read(reg_addr(nebula_pkg::REGION_SRAM, i * 17), rd);
            check_data($sformatf("sram[%0d]", i * 17), ref_mem[i], rd);
        end
    endtask

    task automatic unmapped_access();
        nebula_pkg::wb_data_t rd;
        wb_read(reg_addr(4'd9, 5), rd);                 // Dead region reads zero
        check_data("unmapped read", 32'h0, rd);
        wb_write(reg_addr(4'hf, 0), $random(seed), 4'hf);
        wb_read(reg_addr(team_region(2), 1), rd);       // Team 2 never enabled
        check_data("team2 count", 32'h0, rd);
    endtask

    task automatic team_counter();
        nebula_pkg::wb_data_t  c2;
        nebula_pkg::wb_data_t  rd;
        nebula_pkg::wb_data_t  lo;
        nebula_pkg::wb_data_t  hi;
        nebula_pkg::gpio_vec_t pads_in;
        wb_write(reg_addr(team_region(1), 0), 32'h1, 4'hf);
        repeat (8) @(posedge wb_clk_i);
        wb_write(reg_addr(team_region(1), 0), 32'h0, 4'hf);     // Freeze
        wb_read(reg_addr(team_region(1), 1), c1);
        wb_read(reg_addr(team_region(1), 1), c2);
        check_data("team1 count reread", c1, c2);
        if (c1 == '0)
            abort_run("team 1 counter did not advance while enabled");
        for (int w = 0; w < 5; w++) begin
            wb_write(reg_addr(nebula_pkg::REGION_GPIO, w), 32'h1111_1111, 4'hf);
        end
        wb_read(reg_addr(nebula_pkg::REGION_GPIO, 4), rd);
        check_data("gpio_sel[4]", 32'h0011_1111, rd);       // Pads 32..37 only
        wb_write(reg_addr(team_region(1), 0), 32'h2, 4'hf);     // Drive pads while stopped
        @(negedge wb_clk_i);
        check_gpio("io_out_o", nebula_pkg::gpio_vec_t'(c1), io_out_o);
        check_gpio("io_oeb_o", '0, io_oeb_o);
        lo = $random(seed);
        hi = $random(seed);
        pads_in = {hi[5:0], lo};
        @(posedge wb_clk_i);
        io_in_i <= pads_in;
        wb_read(reg_addr(team_region(1), 2), rd);
        check_data("team1 pad inputs", pads_in[31:0], rd);
    endtask

    task automatic la_routing();
        nebula_pkg::wb_data_t rd;
        wb_write(reg_addr(nebula_pkg::REGION_LA, 0), 32'h0000_0201, 4'hf);
        wb_read(reg_addr(nebula_pkg::REGION_LA, 0), rd);
        check_data("la_sel", 32'h0000_0201, rd);
        @(negedge wb_clk_i);
        // Lane 2 carries team 2's id and lane 0 team 1's count
        check_la("la_data_out_o", {32'h0, 32'h2, 32'h0, c1}, la_data_out_o);
    endtask

    task automatic gpio_partial_select();
        nebula_pkg::wb_data_t  rd;
        nebula_pkg::wb_data_t  new_word;
        nebula_pkg::wb_data_t  exp_word;
        nebula_pkg::wb_sel_t   sel;
        nebula_pkg::gpio_vec_t exp_out;
        nebula_pkg::gpio_vec_t exp_oeb;
        nebula_pkg::team_idx_t owner;
        new_word = 32'h7777_2222;
        sel      = 4'b0101;
        exp_word = 32'h1111_1111;
        for (int b = 0; b < 4; b++) begin
            if (sel[b])
                exp_word[8*b +: 8] = new_word[8*b +: 8];
        end
        wb_write(reg_addr(nebula_pkg::REGION_GPIO, 0), new_word, sel);
        wb_read(reg_addr(nebula_pkg::REGION_GPIO, 0), rd);
        check_data("gpio_sel[0]", exp_word, rd);
        exp_out = nebula_pkg::gpio_vec_t'(c1);
        exp_oeb = '0;
        for (int p = 0; p < 8; p++) begin
            owner = exp_word[4*p +: 4];
            if (owner != 4'd1) begin              // Team 2 idle and 7 out of range
                exp_out[p] = 1'b0;
                exp_oeb[p] = 1'b1;
            end
        end
        @(negedge wb_clk_i);
        check_gpio("io_out_o", exp_out, io_out_o);
        check_gpio("io_oeb_o", exp_oeb, io_oeb_o);
    endtask

    // Watchdog at 200 cycles per test plus slack
    initial begin
        #(CLK_PERIOD * (200 * NUM_TESTS + 100));
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        rst_n_i   = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = '0;
        wbs_dat_i = '0;
        wbs_adr_i = '0;
        io_in_i   = '0;
        c1        = '0;
        repeat (2) @(posedge wb_clk_i);
        rst_n_i <= 1'b1;
        reset_state();
        sram_byte_lanes();
        unmapped_access();
        team_counter();
        la_routing();
        gpio_partial_select();
        $display("test passed");
        $finish;
    end

endmodule

/* all.f */
hdl/nebula_pkg.sv
hdl/wb_decoder.sv
hdl/gpio_control.sv
hdl/la_control.sv
hdl/wb_sram.sv
hdl/team_sample.sv
hdl/nebula_ii.sv
tests/tb_nebula_ii.sv
